// File: dht_huff.f
+incdir+test
verilog/dht_pkg.sv
verilog/dht_symbol_ram.sv
verilog/dht_code_bands.sv
verilog/dht_segment_parser.sv
verilog/dht_lookup_pipe.sv
verilog/jpeg_dht_top.sv
test/tb_jpeg_dht.sv

// File: test/tb_dht_model.svh
// Huffman table model, config stream builder and reference lookup
`ifndef TB_DHT_MODEL_SVH
`define TB_DHT_MODEL_SVH

int            model_cnt [4][16];
logic [7:0]    model_sym [4][256];
int            model_total [4];
dht_cfg_beat_t stream_q [$];
int            seed;

// Count bytes packed with length 1 in the top byte
task automatic load_model(input int tbl, input logic [127:0] cnt_bytes);
    model_total[tbl] = 0;
    for (int l = 0; l < 16; l++)
    begin
        model_cnt[tbl][l] = cnt_bytes[127 - 8 * l -: 8];
        model_total[tbl] += model_cnt[tbl][l];
    end
    for (int k = 0; k < model_total[tbl]; k++)
        model_sym[tbl][k] = 8'($random(seed));
endtask

// Selector, sixteen counts, then the symbols, no last flag
task automatic append_table(input int tbl, input logic [7:0] sel);
    stream_q.push_back({sel, 1'b0});
    for (int l = 0; l < 16; l++)
        stream_q.push_back({8'(model_cnt[tbl][l]), 1'b0});
    for (int k = 0; k < model_total[tbl]; k++)
        stream_q.push_back({model_sym[tbl][k], 1'b0});
endtask

// Aborted table, last flag on the final count byte
task automatic append_partial(input logic [7:0] sel, input int n);
    stream_q.push_back({sel, 1'b0});
    for (int i = 0; i < n; i++)
        stream_q.push_back({8'(i + 1), (i == n - 1)});
endtask

// Left aligned window of symbol k, random bits after the code
function automatic logic [15:0] window_for(input int tbl, input int k);
    int          code;
    int          n;
    logic [31:0] rnd;
    code = 0;
    n = 0;
    for (int l = 1; l <= 16; l++)
    begin
        for (int i = 0; i < model_cnt[tbl][l - 1]; i++)
        begin
            if (n == k)
            begin
                rnd = $random(seed);
                return 16'(code << (16 - l)) | 16'(rnd[15:0] >> l);
            end
            code++;
            n++;
        end
        code = code << 1;
    end
    return 16'h0000;
endfunction

// Canonical decode, codes ascending in length order, first match wins
function automatic dht_lookup_rsp_t ref_lookup(input int tbl, input logic [15:0] window);
    dht_lookup_rsp_t rsp;
    int              code;
    int              n;
    rsp = '0;
    code = 0;
    n = 0;
    for (int l = 1; l <= 16; l++)
    begin
        for (int i = 0; i < model_cnt[tbl][l - 1]; i++)
        begin
            if (int'(window >> (16 - l)) == code)
            begin
                rsp.len = 5'(l);
                rsp.symbol = model_sym[tbl][n];
                return rsp;
            end
            code++;
            n++;
        end
        code = code << 1;
    end
    return rsp;
endfunction

`endif

// File: test/tb_jpeg_dht.sv
// Testbench for the Huffman table decoder with model, compare process and watchdog
module tb_jpeg_dht;
    timeunit 1ns;
    timeprecision 1ps;
    import dht_pkg::*;

    localparam logic [127:0] CNT_Y_DC  = 128'h01010101_01010102_00000000_00000000;
    localparam logic [127:0] CNT_Y_AC  = 128'h00010202_03000200_00000000_00000000;
    localparam logic [127:0] CNT_CX_DC = 128'h00030101_01000000_00000000_00000000;
    localparam logic [127:0] CNT_CX_AC = 128'h00020003_00000400_05000000_00000000;
    localparam int NUM_RANDOM = 200;

    typedef struct packed {
        logic [1:0]  tbl;
        logic [15:0] window;
        logic [31:0] cycle;
    } pending_t;

    logic            clk_i;
    logic            rst_i;
    logic            cfg_valid_i;
    dht_cfg_beat_t   cfg_beat_i;
    logic            cfg_accept_o;
    logic            lookup_req_i;
    dht_lookup_req_t lookup_i;
    logic            lookup_valid_o;
    dht_lookup_rsp_t lookup_rsp_o;

    pending_t    pending_q [$];
    logic [31:0] cycle;
    int          errors;
    int          checks;
    int          tests;
    int          errs_before;
    int          limit_cycles;

    `include "tb_dht_model.svh"

    jpeg_dht_top dut0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_beat_i     (cfg_beat_i),
        .cfg_accept_o   (cfg_accept_o),
        .lookup_req_i   (lookup_req_i),
        .lookup_i       (lookup_i),
        .lookup_valid_o (lookup_valid_o),
        .lookup_rsp_o   (lookup_rsp_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial
    begin
        cycle = 0;
    end

    always @(posedge clk_i)
    begin
        cycle <= cycle + 1;
    end

    //----------------------------------------------------------------------
    // Checking
    //----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Outputs sampled on the falling edge
    always @(negedge clk_i)
    begin : compare_responses
        pending_t        req;
        dht_lookup_rsp_t exp;
        if (!rst_i && lookup_valid_o)
        begin
            if (pending_q.size() == 0)
            begin
                errors++;
                $display("lookup_valid_o high at cycle %0d with no request pending", cycle);
            end
            else
            begin
                req = pending_q.pop_front();
                if (req.cycle + 2 != cycle)
                begin
                    errors++;
                    $display("response at cycle %0d for a request issued at cycle %0d",
                             cycle, req.cycle);
                end
                exp = ref_lookup(req.tbl, req.window);
                check_value("lookup_rsp_o.len", 32'(lookup_rsp_o.len), 32'(exp.len));
                check_value("lookup_rsp_o.symbol", 32'(lookup_rsp_o.symbol),
                            32'(exp.symbol));
            end
        end
        else if (!rst_i && pending_q.size() > 0 && pending_q[0].cycle + 2 <= cycle)
        begin
            req = pending_q.pop_front();
            errors++;
            $display("no response for the request issued at cycle %0d", req.cycle);
        end
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    task automatic send_beat(input dht_cfg_beat_t beat);
        cfg_valid_i = 1'b1;
        cfg_beat_i  = beat;
        while (!cfg_accept_o)
        begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1;
        cfg_valid_i = 1'b0;
    endtask

    // Gap percentage sets how often valid drops before a beat
    task automatic send_stream(input int gap_pct);
        while (stream_q.size() > 0)
        begin
            if ({$random(seed)} % 100 < gap_pct)
            begin
                repeat (1 + {$random(seed)} % 3) @(posedge clk_i);
                #1;
            end
            send_beat(stream_q.pop_front());
        end
    endtask

    task automatic issue_lookup(input int tbl, input logic [15:0] window);
        pending_t p;
        lookup_req_i    = 1'b1;
        lookup_i.tbl    = dht_table_e'(tbl);
        lookup_i.window = window;
        p.tbl    = 2'(tbl);
        p.window = window;
        p.cycle  = cycle;
        pending_q.push_back(p);
        @(posedge clk_i);
        #1;
    endtask

    task automatic drain_lookups();
        lookup_req_i = 1'b0;
        while (pending_q.size() != 0)
        begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic lookup_all_codes(input int tbl);
        for (int k = 0; k < model_total[tbl]; k++)
            issue_lookup(tbl, window_for(tbl, k));
        drain_lookups();
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: FAILED with %0d errors", name, errors - errs_before);
        errs_before = errors;
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial
    begin : run_tests
        int tbl;
        int beats;
        int lookups;
        rst_i        = 1'b1;
        cfg_valid_i  = 1'b0;
        cfg_beat_i   = '0;
        lookup_req_i = 1'b0;
        lookup_i     = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        errs_before  = 0;
        seed         = 32'ha5363c19;

        load_model(0, CNT_Y_DC);
        load_model(1, CNT_Y_AC);
        load_model(2, CNT_CX_DC);
        load_model(3, CNT_CX_AC);

        // Five table loads, one aborted table, every code looked up
        beats = 5 * 17 + 5;
        lookups = NUM_RANDOM + model_total[0] + model_total[3];
        for (int t = 0; t < 4; t++)
        begin
            beats += model_total[t];
            lookups += model_total[t];
        end
        beats += model_total[3];
        limit_cycles = (beats + lookups) * 4 + 200;

        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        check_value("lookup_valid_o", 32'(lookup_valid_o), 32'd0);
        check_value("cfg_accept_o", 32'(cfg_accept_o), 32'd1);
        report_test("test 1 reset state");

        append_table(0, DHT_SEL_Y_DC);
        send_stream(0);
        lookup_all_codes(0);
        report_test("test 2 Y DC table without empty lengths");

        append_table(3, DHT_SEL_CX_AC);
        send_stream(40);
        lookup_all_codes(3);
        report_test("test 3 Cx AC table with empty lengths under stall");

        append_table(1, DHT_SEL_Y_AC);
        append_table(2, DHT_SEL_CX_DC);
        send_stream(0);
        lookup_all_codes(1);
        lookup_all_codes(2);
        report_test("test 4 two tables back to back");

        // Selector 0x23 falls through to Cx AC
        load_model(3, CNT_CX_AC);
        append_partial(DHT_SEL_Y_DC, 4);
        append_table(3, 8'h23);
        send_stream(20);
        lookup_all_codes(3);
        lookup_all_codes(0);
        report_test("test 5 early end on last flag");

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            tbl = {$random(seed)} % 4;
            issue_lookup(tbl, window_for(tbl, {$random(seed)} % model_total[tbl]));
        end
        drain_lookups();
        report_test("test 6 back to back random lookups");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        #1;
        repeat (limit_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/dht_code_bands.sv
// Code band register file with table end-code read and single band read
module dht_code_bands (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  dht_pkg::dht_band_wr_t band_wr_i,
    input  dht_pkg::dht_table_e   match_table_i,
    output logic [dht_pkg::DHT_MAX_LEN-1:0][dht_pkg::DHT_CODE_W-1:0] end_codes_o,
    input  dht_pkg::dht_table_e   band_table_i,
    input  logic [3:0]            band_len_i,
    output dht_pkg::dht_band_t    band_o
);
    import dht_pkg::*;

    localparam int NUM_TABLES = 4;

    dht_band_t bands_q [NUM_TABLES][DHT_MAX_LEN];

    //------------------------------------------------------------------
    // Write port
    //------------------------------------------------------------------
    // Zero bands make an unloaded table fall through to length 16
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int t = 0; t < NUM_TABLES; t++)
            begin
                for (int l = 0; l < DHT_MAX_LEN; l++)
                    bands_q[t][l] <= '0;
            end
        end
        else if (band_wr_i.en)
        begin
            bands_q[band_wr_i.tbl][band_wr_i.len] <= band_wr_i.band;
        end
    end

    //------------------------------------------------------------------
    // Read ports
    //------------------------------------------------------------------
    // All end codes of one table for the length search
    always_comb
    begin
        for (int l = 0; l < DHT_MAX_LEN; l++)
            end_codes_o[l] = bands_q[match_table_i][l].end_code;
    end

    // Full band for the symbol address
    assign band_o = bands_q[band_table_i][band_len_i];

endmodule

// File: verilog/dht_lookup_pipe.sv
// Two-stage Huffman lookup with length search and symbol address
module dht_lookup_pipe (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     lookup_req_i,
    input  dht_pkg::dht_lookup_req_t lookup_i,
    output dht_pkg::dht_table_e      match_table_o,
    input  logic [dht_pkg::DHT_MAX_LEN-1:0][dht_pkg::DHT_CODE_W-1:0] end_codes_i,
    output dht_pkg::dht_table_e      band_table_o,
    output logic [3:0]               band_len_o,
    input  dht_pkg::dht_band_t       band_i,
    output logic [dht_pkg::DHT_PTR_W-1:0] rd_addr_o,
    input  logic [7:0]               rd_data_i,
    output logic                     lookup_valid_o,
    output dht_pkg::dht_lookup_rsp_t lookup_rsp_o
);
    import dht_pkg::*;

    logic [3:0]            match_len;

    logic                  s1_valid_q;
    dht_table_e            s1_table_q;
    logic [DHT_CODE_W-1:0] s1_window_q;
    logic [3:0]            s1_len_q;

    logic                  s2_valid_q;
    logic [4:0]            s2_len_q;

    logic [DHT_CODE_W-1:0] s1_code;
    logic [DHT_CODE_W-1:0] s1_addr;

    // Top len+1 bits of the window, right aligned
    function automatic logic [DHT_CODE_W-1:0] prefix_of(
        input logic [DHT_CODE_W-1:0] window,
        input logic [3:0]            len
    );
        prefix_of = window >> (4'd15 - len);
    endfunction

    //------------------------------------------------------------------
    // Stage 1: shortest matching length
    //------------------------------------------------------------------
    assign match_table_o = lookup_i.tbl;

    // Scan downwards so the shortest match is left standing
    always_comb
    begin
        match_len = 4'd15;
        for (int i = DHT_MAX_LEN - 2; i >= 0; i--)
        begin
            if (prefix_of(lookup_i.window, 4'(i)) < end_codes_i[i])
                match_len = 4'(i);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            s1_valid_q <= 1'b0;
        else
            s1_valid_q <= lookup_req_i;
    end

    always_ff @(posedge clk_i)
    begin
        s1_table_q  <= lookup_i.tbl;
        s1_window_q <= lookup_i.window;
        s1_len_q    <= match_len;
    end

    //------------------------------------------------------------------
    // Stage 2: symbol address and RAM read
    //------------------------------------------------------------------
    assign band_table_o = s1_table_q;
    assign band_len_o   = s1_len_q;

    assign s1_code   = prefix_of(s1_window_q, s1_len_q);
    assign s1_addr   = s1_code - band_i.min_code + {6'b0, band_i.ptr};
    assign rd_addr_o = s1_addr[DHT_PTR_W-1:0];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            s2_valid_q <= 1'b0;
        else
            s2_valid_q <= s1_valid_q;
    end

    // Length index to bit count
    always_ff @(posedge clk_i)
    begin
        s2_len_q <= {1'b0, s1_len_q} + 5'd1;
    end

    assign lookup_valid_o      = s2_valid_q;
    assign lookup_rsp_o.len    = s2_len_q;
    assign lookup_rsp_o.symbol = rd_data_i;

    // Fixed two-cycle latency, no drops
    a_valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        lookup_valid_o == $past(lookup_req_i, 2));

endmodule

// File: verilog/dht_pkg.sv
// Huffman table decoder constants, table enumeration and bus structs
package dht_pkg;

    //------------------------------------------------------------------
    // Sizes
    //------------------------------------------------------------------
    localparam int DHT_MAX_LEN      = 16;
    localparam int DHT_CODE_W       = 16;
    localparam int DHT_PTR_W        = 10;
    localparam int DHT_RAM_DEPTH    = 1024;
    localparam int DHT_CNT_IDX_LAST = 15;

    // Byte index while waiting for a selector byte
    localparam logic [11:0] DHT_IDX_IDLE = 12'hFFF;

    // Selector byte values of the four tables
    localparam logic [7:0] DHT_SEL_Y_DC  = 8'h00;
    localparam logic [7:0] DHT_SEL_Y_AC  = 8'h10;
    localparam logic [7:0] DHT_SEL_CX_DC = 8'h01;
    localparam logic [7:0] DHT_SEL_CX_AC = 8'h11;

    //------------------------------------------------------------------
    // Types
    //------------------------------------------------------------------
    typedef enum logic [1:0] {
        Y_DC  = 2'd0,
        Y_AC  = 2'd1,
        CX_DC = 2'd2,
        CX_AC = 2'd3
    } dht_table_e;

    // One config stream beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } dht_cfg_beat_t;

    // End code is one past the largest code of the length
    typedef struct packed {
        logic [DHT_CODE_W-1:0] min_code;
        logic [DHT_CODE_W-1:0] end_code;
        logic [DHT_PTR_W-1:0]  ptr;
    } dht_band_t;

    typedef struct packed {
        logic       en;
        dht_table_e tbl;
        logic [3:0] len;
        dht_band_t  band;
    } dht_band_wr_t;

    typedef struct packed {
        logic                 en;
        logic [DHT_PTR_W-1:0] addr;
        logic [7:0]           data;
    } dht_sym_wr_t;

    // Window is left aligned, first stream bit in the MSB
    typedef struct packed {
        dht_table_e            tbl;
        logic [DHT_CODE_W-1:0] window;
    } dht_lookup_req_t;

    typedef struct packed {
        logic [4:0] len;
        logic [7:0] symbol;
    } dht_lookup_rsp_t;

endpackage

// File: verilog/dht_segment_parser.sv
// DHT segment parser building canonical code bands and symbol writes
module dht_segment_parser (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cfg_valid_i,
    input  dht_pkg::dht_cfg_beat_t cfg_beat_i,
    output logic                   cfg_accept_o,
    output dht_pkg::dht_band_wr_t  band_wr_o,
    output dht_pkg::dht_sym_wr_t   sym_wr_o
);
    import dht_pkg::*;

    logic [11:0]           idx_q;
    dht_table_e            table_q;
    logic [7:0]            counts_q [DHT_MAX_LEN];
    logic [DHT_MAX_LEN-1:0] nonempty_q;
    logic [11:0]           total_q;

    logic [3:0]            len_q;
    logic [7:0]            sym_cnt_q;
    logic [DHT_CODE_W-1:0] code_q;
    logic [DHT_PTR_W-1:0]  ptr_q;

    logic       cnt_phase;
    logic       sym_phase;
    logic       beat_fire;
    logic       cnt_fire;
    logic       sym_fire;
    logic       table_done;
    logic       end_fire;
    logic [11:0] total_next;
    dht_table_e sel_table;

    //------------------------------------------------------------------
    // Phase decode and handshake
    //------------------------------------------------------------------
    assign cnt_phase = (idx_q <= 12'(DHT_CNT_IDX_LAST));
    assign sym_phase = !cnt_phase && (idx_q != DHT_IDX_IDLE);

    // Stall the stream while stepping over empty lengths
    assign cfg_accept_o = !sym_phase || nonempty_q[len_q];

    assign beat_fire = cfg_valid_i && cfg_accept_o;
    assign cnt_fire  = beat_fire && cnt_phase;
    assign sym_fire  = beat_fire && sym_phase;

    assign total_next = total_q + {4'b0, cfg_beat_i.data};

    // Symbol total reached, or all counts zero on the last count byte
    always_comb
    begin
        table_done = cfg_beat_i.last;
        if (sym_phase && idx_q == total_q)
            table_done = 1'b1;
        if (idx_q == 12'(DHT_CNT_IDX_LAST) && total_next == 12'(DHT_CNT_IDX_LAST))
            table_done = 1'b1;
    end

    assign end_fire = beat_fire && table_done;

    always_comb
    begin
        case (cfg_beat_i.data)
            DHT_SEL_Y_DC:  sel_table = Y_DC;
            DHT_SEL_Y_AC:  sel_table = Y_AC;
            DHT_SEL_CX_DC: sel_table = CX_DC;
            DHT_SEL_CX_AC: sel_table = CX_AC;
            default:       sel_table = CX_AC;
        endcase
    end

    //------------------------------------------------------------------
    // Byte index, table select and counts
    //------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            idx_q <= DHT_IDX_IDLE;
        else if (end_fire)
            idx_q <= DHT_IDX_IDLE;
        else if (beat_fire)
            idx_q <= idx_q + 12'd1;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            table_q <= Y_DC;
        else if (beat_fire && idx_q == DHT_IDX_IDLE)
            table_q <= sel_table;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i || end_fire)
        begin
            for (int i = 0; i < DHT_MAX_LEN; i++)
                counts_q[i] <= 8'd0;
            nonempty_q <= '0;
            total_q    <= 12'(DHT_CNT_IDX_LAST);
        end
        else if (cnt_fire)
        begin
            counts_q[idx_q[3:0]]   <= cfg_beat_i.data;
            nonempty_q[idx_q[3:0]] <= (cfg_beat_i.data != 8'd0);
            total_q                <= total_next;
        end
    end

    //------------------------------------------------------------------
    // Canonical code walk
    //------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !sym_phase)
        begin
            len_q     <= 4'd0;
            sym_cnt_q <= 8'd0;
            code_q    <= '0;
        end
        else if (sym_fire)
        begin
            if (sym_cnt_q + 8'd1 == counts_q[len_q])
            begin
                len_q     <= len_q + 4'd1;
                sym_cnt_q <= 8'd0;
                code_q    <= (code_q + 1'b1) << 1;
            end
            else
            begin
                sym_cnt_q <= sym_cnt_q + 8'd1;
                code_q    <= code_q + 1'b1;
            end
        end
        // Empty length, one step per stalled cycle
        else if (cfg_valid_i && !cfg_accept_o)
        begin
            len_q  <= len_q + 4'd1;
            code_q <= code_q << 1;
        end
    end

    // Pointer runs across all tables of the stream
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            ptr_q <= '0;
        else if (sym_fire)
            ptr_q <= ptr_q + 1'b1;
    end

    //------------------------------------------------------------------
    // Band and symbol writes
    //------------------------------------------------------------------
    always_comb
    begin
        band_wr_o.en            = sym_fire && (sym_cnt_q == 8'd0);
        band_wr_o.tbl           = table_q;
        band_wr_o.len           = len_q;
        band_wr_o.band.min_code = code_q;
        band_wr_o.band.end_code = code_q + {8'b0, counts_q[len_q]};
        band_wr_o.band.ptr      = ptr_q;
    end

    assign sym_wr_o.en   = sym_fire;
    assign sym_wr_o.addr = ptr_q;
    assign sym_wr_o.data = cfg_beat_i.data;

    // Symbol memory is never overrun
    a_ptr_no_wrap: assert property (@(posedge clk_i) disable iff (rst_i)
        sym_wr_o.en |=> ptr_q != '0);

endmodule

// File: verilog/dht_symbol_ram.sv
// Symbol memory with one write port and a synchronous read port
module dht_symbol_ram (
    input  logic                          clk_i,
    input  dht_pkg::dht_sym_wr_t          sym_wr_i,
    input  logic [dht_pkg::DHT_PTR_W-1:0] rd_addr_i,
    output logic [7:0]                    rd_data_o
);
    import dht_pkg::*;

    logic [7:0] mem_q [DHT_RAM_DEPTH];
    logic [7:0] rd_data_q;

    always_ff @(posedge clk_i)
    begin
        if (sym_wr_i.en)
            mem_q[sym_wr_i.addr] <= sym_wr_i.data;
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk_i)
    begin
        rd_data_q <= mem_q[rd_addr_i];
    end

    assign rd_data_o = rd_data_q;

endmodule

// File: verilog/jpeg_dht_top.sv
// Writable JPEG Huffman table decoder top level
module jpeg_dht_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     cfg_valid_i,
    input  dht_pkg::dht_cfg_beat_t   cfg_beat_i,
    output logic                     cfg_accept_o,
    input  logic                     lookup_req_i,
    input  dht_pkg::dht_lookup_req_t lookup_i,
    output logic                     lookup_valid_o,
    output dht_pkg::dht_lookup_rsp_t lookup_rsp_o
);
    import dht_pkg::*;

    dht_band_wr_t band_wr;
    dht_sym_wr_t  sym_wr;

    dht_table_e   match_table;
    logic [DHT_MAX_LEN-1:0][DHT_CODE_W-1:0] end_codes;
    dht_table_e   band_table;
    logic [3:0]   band_len;
    dht_band_t    band;

    logic [DHT_PTR_W-1:0] rd_addr;
    logic [7:0]           rd_data;

    //------------------------------------------------------------------
    // Table load path
    //------------------------------------------------------------------
    dht_segment_parser u_parser (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_beat_i   (cfg_beat_i),
        .cfg_accept_o (cfg_accept_o),
        .band_wr_o    (band_wr),
        .sym_wr_o     (sym_wr)
    );

    dht_code_bands u_bands (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .band_wr_i     (band_wr),
        .match_table_i (match_table),
        .end_codes_o   (end_codes),
        .band_table_i  (band_table),
        .band_len_i    (band_len),
        .band_o        (band)
    );

    //------------------------------------------------------------------
    // Lookup path
    //------------------------------------------------------------------
    dht_lookup_pipe u_lookup (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_req_i   (lookup_req_i),
        .lookup_i       (lookup_i),
        .match_table_o  (match_table),
        .end_codes_i    (end_codes),
        .band_table_o   (band_table),
        .band_len_o     (band_len),
        .band_i         (band),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .lookup_valid_o (lookup_valid_o),
        .lookup_rsp_o   (lookup_rsp_o)
    );

    dht_symbol_ram u_ram (
        .clk_i     (clk_i),
        .sym_wr_i  (sym_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

endmodule
